// File: source/periph_bus_pkg.sv
// One 32-bit APB slave port with zero wait states; slot field at paddr[15:12], slots 2-15 error
package periph_bus_pkg;

    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam int SLOT_SEL_LSB = 12;
    localparam int SLOT_SEL_W   = 4;
    localparam int SLOT_PLIC    = 0;
    localparam int SLOT_TIMER   = 1;

    // Read data of an absent peripheral
    localparam logic [APB_DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

    // Timer block layout
    localparam int         NUM_TIMERS      = 2;
    localparam int         TIMER_STRIDE    = 16;
    localparam logic [3:0] TIMER_CTRL_OFS  = 4'h0;
    localparam logic [3:0] TIMER_COUNT_OFS = 4'h4;
    localparam logic [3:0] TIMER_CMP_OFS   = 4'h8;

endpackage

// File: source/periph_irq_pkg.sv
// Four level sources (0-1 external, 2-3 timers), two targets; ID 0 means no interrupt
package periph_irq_pkg;

    localparam int NUM_SOURCES = 4;
    localparam int NUM_TARGETS = 2;
    localparam int PRIO_W      = 3;

    typedef logic [PRIO_W-1:0] prio_t;
    // Source i carries ID i+1
    typedef logic [2:0] irq_id_t;

    // ------------------------------------------------------------
    // Register offsets inside the interrupt controller slot
    // ------------------------------------------------------------
    // 4 bytes per source
    localparam logic [11:0] PLIC_PRIO_OFS    = 12'h000;
    localparam logic [11:0] PLIC_PENDING_OFS = 12'h080;
    // 4 bytes per target from here on
    localparam logic [11:0] PLIC_ENABLE_OFS  = 12'h100;
    localparam logic [11:0] PLIC_THRESH_OFS  = 12'h200;
    localparam logic [11:0] PLIC_CLAIM_OFS   = 12'h300;

endpackage

// File: source/apb_slot_demux.sv
// Zero-wait-state slots only; the slot field is decoded in the setup and access cycles alike
`timescale 1ns/100ps

module apb_slot_demux (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  periph_bus_pkg::apb_req_t apb_req_i,
    output periph_bus_pkg::apb_rsp_t apb_rsp_o,
    output periph_bus_pkg::apb_req_t plic_req_o,
    output periph_bus_pkg::apb_req_t timer_req_o,
    input  periph_bus_pkg::apb_rsp_t plic_rsp_i,
    input  periph_bus_pkg::apb_rsp_t timer_rsp_i
);

    logic [periph_bus_pkg::SLOT_SEL_W-1:0] slot;
    logic                                  access;

    assign slot   = apb_req_i.paddr[periph_bus_pkg::SLOT_SEL_LSB +: periph_bus_pkg::SLOT_SEL_W];
    assign access = apb_req_i.psel && apb_req_i.penable;

    // Only the addressed slot sees psel
    always_comb begin
        plic_req_o       = apb_req_i;
        timer_req_o      = apb_req_i;
        plic_req_o.psel  = apb_req_i.psel &&
                           (slot == periph_bus_pkg::SLOT_SEL_W'(periph_bus_pkg::SLOT_PLIC));
        timer_req_o.psel = apb_req_i.psel &&
                           (slot == periph_bus_pkg::SLOT_SEL_W'(periph_bus_pkg::SLOT_TIMER));
    end

    always_comb begin
        case (slot)
            periph_bus_pkg::SLOT_SEL_W'(periph_bus_pkg::SLOT_PLIC):  apb_rsp_o = plic_rsp_i;
            periph_bus_pkg::SLOT_SEL_W'(periph_bus_pkg::SLOT_TIMER): apb_rsp_o = timer_rsp_i;
            default: begin
                // Absent peripheral
                apb_rsp_o.prdata  = periph_bus_pkg::ERR_RDATA;
                apb_rsp_o.pready  = access;
                apb_rsp_o.pslverr = access;
            end
        endcase
    end

    // Every slot, the error one included, answers in the access cycle only
    a_pready_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable)
    );

endmodule

// File: source/timer_regs.sv
// Timers at 16-byte stride; CTRL bit 0 enables, COUNT writes load the core at the same edge
`timescale 1ns/100ps

module timer_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  periph_bus_pkg::apb_req_t apb_req_i,
    output periph_bus_pkg::apb_rsp_t apb_rsp_o,
    input  logic [periph_bus_pkg::NUM_TIMERS-1:0][periph_bus_pkg::APB_DATA_W-1:0] count_i,
    output logic [periph_bus_pkg::NUM_TIMERS-1:0]                            enable_o,
    output logic [periph_bus_pkg::NUM_TIMERS-1:0][periph_bus_pkg::APB_DATA_W-1:0] cmp_o,
    output logic [periph_bus_pkg::NUM_TIMERS-1:0]                            load_o,
    output logic [periph_bus_pkg::APB_DATA_W-1:0]                            load_val_o
);

    localparam int IDX_LSB = $clog2(periph_bus_pkg::TIMER_STRIDE);
    localparam int IDX_W   = periph_bus_pkg::SLOT_SEL_LSB - IDX_LSB;

    logic               access;
    logic               wr;
    logic [IDX_LSB-1:0] reg_ofs;
    logic [IDX_W-1:0]   idx;

    assign access  = apb_req_i.psel && apb_req_i.penable;
    assign wr      = access && apb_req_i.pwrite;
    assign reg_ofs = apb_req_i.paddr[IDX_LSB-1:0];
    assign idx     = apb_req_i.paddr[periph_bus_pkg::SLOT_SEL_LSB-1:IDX_LSB];

    assign load_val_o = apb_req_i.pwdata;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_o <= '0;
            cmp_o    <= '0;
        end else begin
            for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin
                if (wr && idx == IDX_W'(i)) begin
                    if (reg_ofs == periph_bus_pkg::TIMER_CTRL_OFS)
                        enable_o[i] <= apb_req_i.pwdata[0];
                    if (reg_ofs == periph_bus_pkg::TIMER_CMP_OFS)
                        cmp_o[i] <= apb_req_i.pwdata;
                end
            end
        end
    end

    // Read mux and load strobes
    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = access;
        apb_rsp_o.pslverr = access && (idx >= IDX_W'(periph_bus_pkg::NUM_TIMERS));
        load_o            = '0;
        for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin
            if (idx == IDX_W'(i)) begin
                case (reg_ofs)
                    periph_bus_pkg::TIMER_CTRL_OFS:  apb_rsp_o.prdata = 32'(enable_o[i]);
                    periph_bus_pkg::TIMER_COUNT_OFS: apb_rsp_o.prdata = count_i[i];
                    periph_bus_pkg::TIMER_CMP_OFS:   apb_rsp_o.prdata = cmp_o[i];
                    default:                         apb_rsp_o.prdata = '0;
                endcase
                load_o[i] = wr && (reg_ofs == periph_bus_pkg::TIMER_COUNT_OFS);
            end
        end
    end

endmodule

// File: source/timer_core.sv
// Count wraps to 0 after matching compare; a load wins over counting and over the wrap
`timescale 1ns/100ps

module timer_core (
    input  logic                                                          clk_i,
    input  logic                                                          rst_n_i,
    input  logic [periph_bus_pkg::NUM_TIMERS-1:0]                         enable_i,
    input  logic [periph_bus_pkg::NUM_TIMERS-1:0][periph_bus_pkg::APB_DATA_W-1:0] cmp_i,
    input  logic [periph_bus_pkg::NUM_TIMERS-1:0]                         load_i,
    input  logic [periph_bus_pkg::APB_DATA_W-1:0]                         load_val_i,
    output logic [periph_bus_pkg::NUM_TIMERS-1:0][periph_bus_pkg::APB_DATA_W-1:0] count_o,
    output logic [periph_bus_pkg::NUM_TIMERS-1:0]                         hit_o
);

    always_comb begin
        for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin
            hit_o[i] = enable_i[i] && (count_o[i] == cmp_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else begin
            for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin
                if (load_i[i])
                    count_o[i] <= load_val_i;
                else if (hit_o[i])
                    count_o[i] <= '0;
                else if (enable_i[i])
                    count_o[i] <= count_o[i] + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin : g_chk
        // A disabled timer neither counts nor wraps unless loaded
        a_disabled_holds: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (!enable_i[i] && !load_i[i]) |=> $stable(count_o[i])
        );
    end

endmodule

// File: source/plic_regs.sv
// Claim read returns the best ID even below threshold; complete writes take the ID from pwdata
`timescale 1ns/100ps

module plic_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  periph_bus_pkg::apb_req_t apb_req_i,
    output periph_bus_pkg::apb_rsp_t apb_rsp_o,
    input  logic [periph_irq_pkg::NUM_SOURCES-1:0]                    pending_i,
    input  periph_irq_pkg::irq_id_t [periph_irq_pkg::NUM_TARGETS-1:0] best_id_i,
    output periph_irq_pkg::prio_t [periph_irq_pkg::NUM_SOURCES-1:0]   prio_o,
    output logic [periph_irq_pkg::NUM_TARGETS-1:0][periph_irq_pkg::NUM_SOURCES-1:0] enable_o,
    output periph_irq_pkg::prio_t [periph_irq_pkg::NUM_TARGETS-1:0]   thresh_o,
    output logic [periph_irq_pkg::NUM_TARGETS-1:0]                    claim_o,
    output logic [periph_irq_pkg::NUM_TARGETS-1:0]                    complete_o,
    output periph_irq_pkg::irq_id_t                                   complete_id_o
);

    localparam int NS = periph_irq_pkg::NUM_SOURCES;
    localparam int NT = periph_irq_pkg::NUM_TARGETS;

    logic        access;
    logic        wr;
    logic [11:0] ofs;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr     = access && apb_req_i.pwrite;
    assign ofs    = apb_req_i.paddr[11:0];

    assign complete_id_o = apb_req_i.pwdata[$bits(periph_irq_pkg::irq_id_t)-1:0];

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_o   <= '0;
            enable_o <= '0;
            thresh_o <= '0;
        end else if (wr) begin
            for (int s = 0; s < NS; s++) begin
                if (ofs == periph_irq_pkg::PLIC_PRIO_OFS + 12'(4 * s))
                    prio_o[s] <= apb_req_i.pwdata[periph_irq_pkg::PRIO_W-1:0];
            end
            for (int t = 0; t < NT; t++) begin
                if (ofs == periph_irq_pkg::PLIC_ENABLE_OFS + 12'(4 * t))
                    enable_o[t] <= apb_req_i.pwdata[NS-1:0];
                if (ofs == periph_irq_pkg::PLIC_THRESH_OFS + 12'(4 * t))
                    thresh_o[t] <= apb_req_i.pwdata[periph_irq_pkg::PRIO_W-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // Read mux, claim and complete strobes
    // ------------------------------------------------------------
    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = access;
        apb_rsp_o.pslverr = 1'b0;
        claim_o           = '0;
        complete_o        = '0;
        for (int s = 0; s < NS; s++) begin
            if (ofs == periph_irq_pkg::PLIC_PRIO_OFS + 12'(4 * s))
                apb_rsp_o.prdata = 32'(prio_o[s]);
        end
        // Read only
        if (ofs == periph_irq_pkg::PLIC_PENDING_OFS)
            apb_rsp_o.prdata = 32'(pending_i);
        for (int t = 0; t < NT; t++) begin
            if (ofs == periph_irq_pkg::PLIC_ENABLE_OFS + 12'(4 * t))
                apb_rsp_o.prdata = 32'(enable_o[t]);
            if (ofs == periph_irq_pkg::PLIC_THRESH_OFS + 12'(4 * t))
                apb_rsp_o.prdata = 32'(thresh_o[t]);
            if (ofs == periph_irq_pkg::PLIC_CLAIM_OFS + 12'(4 * t)) begin
                apb_rsp_o.prdata = 32'(best_id_i[t]);
                claim_o[t]       = access && !apb_req_i.pwrite;
                complete_o[t]    = wr;
            end
        end
    end

endmodule

// File: source/plic_core.sv
// Level gateways only; priority 0 never wins and ties go to the lower ID
`timescale 1ns/100ps

module plic_core (
    input  logic                                                      clk_i,
    input  logic                                                      rst_n_i,
    input  logic [periph_irq_pkg::NUM_SOURCES-1:0]                    src_i,
    input  periph_irq_pkg::prio_t [periph_irq_pkg::NUM_SOURCES-1:0]   prio_i,
    input  logic [periph_irq_pkg::NUM_TARGETS-1:0][periph_irq_pkg::NUM_SOURCES-1:0] enable_i,
    input  periph_irq_pkg::prio_t [periph_irq_pkg::NUM_TARGETS-1:0]   thresh_i,
    input  logic [periph_irq_pkg::NUM_TARGETS-1:0]                    claim_i,
    input  logic [periph_irq_pkg::NUM_TARGETS-1:0]                    complete_i,
    input  periph_irq_pkg::irq_id_t                                   complete_id_i,
    output logic [periph_irq_pkg::NUM_SOURCES-1:0]                    pending_o,
    output periph_irq_pkg::irq_id_t [periph_irq_pkg::NUM_TARGETS-1:0] best_id_o,
    output logic [periph_irq_pkg::NUM_TARGETS-1:0]                    irq_o
);

    localparam int NS = periph_irq_pkg::NUM_SOURCES;
    localparam int NT = periph_irq_pkg::NUM_TARGETS;

    // Gateway is idle when neither bit is set
    logic [NS-1:0]                         inflight_q;
    logic [NS-1:0]                         claim_mask;
    logic [NS-1:0]                         done_mask;
    periph_irq_pkg::prio_t [NT-1:0]        best_prio;

    always_comb begin
        best_id_o  = '0;
        best_prio  = '0;
        claim_mask = '0;
        done_mask  = '0;
        for (int t = 0; t < NT; t++) begin
            // Strict compare keeps the lowest ID on ties
            for (int s = 0; s < NS; s++) begin
                if (pending_o[s] && enable_i[t][s] && prio_i[s] > best_prio[t]) begin
                    best_prio[t] = prio_i[s];
                    best_id_o[t] = periph_irq_pkg::irq_id_t'(s + 1);
                end
            end
            irq_o[t] = best_prio[t] > thresh_i[t];
            for (int s = 0; s < NS; s++) begin
                if (claim_i[t] && best_id_o[t] == periph_irq_pkg::irq_id_t'(s + 1))
                    claim_mask[s] = 1'b1;
                if (complete_i[t] && complete_id_i == periph_irq_pkg::irq_id_t'(s + 1))
                    done_mask[s] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_o  <= '0;
            inflight_q <= '0;
        end else begin
            pending_o  <= (pending_o | (src_i & ~inflight_q)) & ~claim_mask;
            inflight_q <= (inflight_q | claim_mask) & ~done_mask;
        end
    end

    for (genvar s = 0; s < NS; s++) begin : g_chk
        // A source only goes in flight out of the pending state
        a_claim_pending: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            $rose(inflight_q[s]) |-> $past(pending_o[s])
        );
    end

endmodule

// File: source/periph_top.sv
// Sources 0-1 are ext_irq_i, 2-3 the timer hits; irq_o[0] machine, irq_o[1] supervisor
`timescale 1ns/100ps

module periph_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  periph_bus_pkg::apb_req_t apb_req_i,
    output periph_bus_pkg::apb_rsp_t apb_rsp_o,
    input  logic [1:0]               ext_irq_i,
    output logic [1:0]               irq_o
);

    localparam int NT = periph_bus_pkg::NUM_TIMERS;
    localparam int DW = periph_bus_pkg::APB_DATA_W;

    periph_bus_pkg::apb_req_t plic_req;
    periph_bus_pkg::apb_req_t timer_req;
    periph_bus_pkg::apb_rsp_t plic_rsp;
    periph_bus_pkg::apb_rsp_t timer_rsp;

    logic [NT-1:0][DW-1:0] timer_count;
    logic [NT-1:0][DW-1:0] timer_cmp;
    logic [NT-1:0]         timer_en;
    logic [NT-1:0]         timer_load;
    logic [DW-1:0]         timer_load_val;
    logic [NT-1:0]         timer_hit;

    logic [periph_irq_pkg::NUM_SOURCES-1:0]                      irq_src;
    logic [periph_irq_pkg::NUM_SOURCES-1:0]                      irq_pending;
    periph_irq_pkg::irq_id_t [periph_irq_pkg::NUM_TARGETS-1:0]   best_id;
    periph_irq_pkg::prio_t [periph_irq_pkg::NUM_SOURCES-1:0]     prio;
    logic [periph_irq_pkg::NUM_TARGETS-1:0][periph_irq_pkg::NUM_SOURCES-1:0] irq_en;
    periph_irq_pkg::prio_t [periph_irq_pkg::NUM_TARGETS-1:0]     thresh;
    logic [periph_irq_pkg::NUM_TARGETS-1:0]                      claim;
    logic [periph_irq_pkg::NUM_TARGETS-1:0]                      complete;
    periph_irq_pkg::irq_id_t                                     complete_id;

    assign irq_src = {timer_hit, ext_irq_i};

    // ------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------
    apb_slot_demux u_demux (
        .clk_i, .rst_n_i, .apb_req_i, .apb_rsp_o,
        .plic_req_o (plic_req),  .timer_req_o (timer_req),
        .plic_rsp_i (plic_rsp),  .timer_rsp_i (timer_rsp)
    );

    // ------------------------------------------------------------
    // Timers
    // ------------------------------------------------------------
    timer_regs u_timer_regs (
        .clk_i, .rst_n_i,
        .apb_req_i (timer_req),   .apb_rsp_o  (timer_rsp),
        .count_i   (timer_count), .enable_o   (timer_en),
        .cmp_o     (timer_cmp),   .load_o     (timer_load),
        .load_val_o (timer_load_val)
    );

    timer_core u_timer_core (
        .clk_i, .rst_n_i,
        .enable_i (timer_en),   .cmp_i      (timer_cmp),
        .load_i   (timer_load), .load_val_i (timer_load_val),
        .count_o  (timer_count), .hit_o     (timer_hit)
    );

    // ------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------
    plic_regs u_plic_regs (
        .clk_i, .rst_n_i,
        .apb_req_i (plic_req),    .apb_rsp_o  (plic_rsp),
        .pending_i (irq_pending), .best_id_i  (best_id),
        .prio_o    (prio),        .enable_o   (irq_en),
        .thresh_o  (thresh),      .claim_o    (claim),
        .complete_o (complete),   .complete_id_o (complete_id)
    );

    plic_core u_plic_core (
        .clk_i, .rst_n_i,
        .src_i      (irq_src),  .prio_i        (prio),
        .enable_i   (irq_en),   .thresh_i      (thresh),
        .claim_i    (claim),    .complete_i    (complete),
        .complete_id_i (complete_id),
        .pending_o  (irq_pending), .best_id_o  (best_id),
        .irq_o
    );

endmodule

// File: sim/periph_tb.sv
// Zero-wait-state APB master; reads and irq_o levels are checked by the assertions in this module
`timescale 1ns/100ps

module periph_tb;

    logic                     clk;
    logic                     rst_n;
    periph_bus_pkg::apb_req_t apb_req;
    periph_bus_pkg::apb_rsp_t apb_rsp;
    logic [1:0]               ext_irq;
    logic [1:0]               irq;

    // Expected read, armed only for the access cycle of a checked read
    logic        rd_chk;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        irq_chk;
    logic [1:0]  exp_irq;

    int          err_cnt;
    int          test_cnt;
    int          cycles = 0;
    int unsigned n_cmp;
    int unsigned rnd;
    logic [31:0] cmp_m [periph_bus_pkg::NUM_TIMERS];
    periph_irq_pkg::prio_t prio_m [periph_irq_pkg::NUM_SOURCES];

    periph_top u_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .ext_irq_i (ext_irq),
        .irq_o     (irq)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Run stopped at the limit of 4000 cycles");
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_chk && apb_req.psel && apb_req.penable) |-> apb_rsp.prdata == exp_rdata)
    else begin
        $display("mismatch t=%0t prdata got %h expected %h",
                 $time, $sampled(apb_rsp.prdata), $sampled(exp_rdata));
        err_cnt++;
    end

    a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_chk && apb_req.psel && apb_req.penable) |-> apb_rsp.pslverr == exp_err)
    else begin
        $display("mismatch t=%0t pslverr got %b expected %b",
                 $time, $sampled(apb_rsp.pslverr), $sampled(exp_err));
        err_cnt++;
    end

    a_irq: assert property (@(posedge clk) disable iff (!rst_n)
        irq_chk |-> irq == exp_irq)
    else begin
        $display("mismatch t=%0t irq_o got %b expected %b",
                 $time, $sampled(irq), $sampled(exp_irq));
        err_cnt++;
    end

    // ------------------------------------------------------------
    // Address helpers and bus tasks
    // ------------------------------------------------------------
    function automatic logic [31:0] timer_addr(input int idx, input logic [3:0] ofs);
        return (32'(periph_bus_pkg::SLOT_TIMER) << periph_bus_pkg::SLOT_SEL_LSB)
               + 32'(idx * periph_bus_pkg::TIMER_STRIDE) + 32'(ofs);
    endfunction

    function automatic logic [31:0] plic_addr(input logic [11:0] ofs, input int idx);
        return (32'(periph_bus_pkg::SLOT_PLIC) << periph_bus_pkg::SLOT_SEL_LSB)
               + 32'(ofs) + 32'(4 * idx);
    endfunction

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        do @(posedge clk); while (!apb_rsp.pready);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp, input logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= '0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        exp_rdata       <= exp;
        exp_err         <= err;
        rd_chk          <= 1'b1;
        do @(posedge clk); while (!apb_rsp.pready);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        rd_chk          <= 1'b0;
    endtask

    task automatic set_irq_check(input logic on, input logic [1:0] exp);
        @(posedge clk);
        irq_chk <= on;
        exp_irq <= exp;
    endtask

    task automatic wait_irq(input int t, input int limit);
        int n;
        n = 0;
        while (!irq[t] && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!irq[t]) begin
            $display("irq_o[%0d] did not rise within %0d cycles, t=%0t", t, limit, $time);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s done, %0d errors so far", test_cnt, name, err_cnt);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'hb2c88d22));
        clk       = 1'b0;
        rst_n     = 1'b0;
        apb_req   = '0;
        ext_irq   = '0;
        rd_chk    = 1'b0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        irq_chk   = 1'b0;
        exp_irq   = '0;
        err_cnt   = 0;
        test_cnt  = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        set_irq_check(1'b1, 2'b00);
        apb_read(timer_addr(0, periph_bus_pkg::TIMER_CTRL_OFS), 32'h0, 1'b0);
        apb_read(timer_addr(1, periph_bus_pkg::TIMER_CTRL_OFS), 32'h0, 1'b0);
        for (int t = 0; t < periph_irq_pkg::NUM_TARGETS; t++)
            apb_read(plic_addr(periph_irq_pkg::PLIC_THRESH_OFS, t), 32'h0, 1'b0);
        apb_read(32'h0000_2000, 32'hdeadbeef, 1'b1);
        end_test("reset values");

        for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++) begin
            cmp_m[i] = $urandom;
            apb_write(timer_addr(i, periph_bus_pkg::TIMER_CMP_OFS), cmp_m[i]);
        end
        for (int i = 0; i < periph_bus_pkg::NUM_TIMERS; i++)
            apb_read(timer_addr(i, periph_bus_pkg::TIMER_CMP_OFS), cmp_m[i], 1'b0);
        for (int s = 0; s < periph_irq_pkg::NUM_SOURCES; s++) begin
            rnd       = $urandom;
            prio_m[s] = rnd[2:0];
            apb_write(plic_addr(periph_irq_pkg::PLIC_PRIO_OFS, s), rnd);
        end
        for (int s = 0; s < periph_irq_pkg::NUM_SOURCES; s++)
            apb_read(plic_addr(periph_irq_pkg::PLIC_PRIO_OFS, s), 32'(prio_m[s]), 1'b0);
        end_test("register readback");

        // Timer 0 is source 2, ID 3
        n_cmp = $urandom_range(40, 8);
        apb_write(timer_addr(0, periph_bus_pkg::TIMER_CMP_OFS), n_cmp);
        apb_write(timer_addr(0, periph_bus_pkg::TIMER_COUNT_OFS), 32'h0);
        apb_write(plic_addr(periph_irq_pkg::PLIC_PRIO_OFS, 2), 32'h3);
        apb_write(plic_addr(periph_irq_pkg::PLIC_THRESH_OFS, 0), 32'h0);
        apb_write(plic_addr(periph_irq_pkg::PLIC_ENABLE_OFS, 0), 32'h4);
        set_irq_check(1'b0, 2'b00);
        apb_write(timer_addr(0, periph_bus_pkg::TIMER_CTRL_OFS), 32'h1);
        wait_irq(0, n_cmp + 4);
        apb_read(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h3, 1'b0);
        apb_write(timer_addr(0, periph_bus_pkg::TIMER_CTRL_OFS), 32'h0);
        apb_write(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h3);
        set_irq_check(1'b1, 2'b00);
        repeat (2 * n_cmp) @(posedge clk);
        apb_read(plic_addr(periph_irq_pkg::PLIC_PENDING_OFS, 0), 32'h0, 1'b0);
        end_test("timer interrupt");

        apb_write(plic_addr(periph_irq_pkg::PLIC_PRIO_OFS, 0), 32'h2);
        apb_write(plic_addr(periph_irq_pkg::PLIC_PRIO_OFS, 1), 32'h5);
        apb_write(plic_addr(periph_irq_pkg::PLIC_ENABLE_OFS, 0), 32'h3);
        set_irq_check(1'b0, 2'b00);
        @(posedge clk);
        ext_irq <= 2'b11;
        wait_irq(0, 4);
        apb_read(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h2, 1'b0);
        apb_read(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h1, 1'b0);
        // Both in flight, so the held levels are ignored
        set_irq_check(1'b1, 2'b00);
        repeat (4) @(posedge clk);
        set_irq_check(1'b0, 2'b00);
        apb_write(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h2);
        apb_write(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 0), 32'h1);
        wait_irq(0, 4);
        repeat (2) @(posedge clk);
        ext_irq <= 2'b00;
        end_test("external priority order");

        apb_read(plic_addr(periph_irq_pkg::PLIC_PENDING_OFS, 0), 32'h3, 1'b0);
        apb_write(plic_addr(periph_irq_pkg::PLIC_THRESH_OFS, 0), 32'h5);
        set_irq_check(1'b1, 2'b00);
        repeat (8) @(posedge clk);
        set_irq_check(1'b0, 2'b00);
        apb_write(plic_addr(periph_irq_pkg::PLIC_ENABLE_OFS, 1), 32'h1);
        set_irq_check(1'b1, 2'b10);
        repeat (8) @(posedge clk);
        set_irq_check(1'b0, 2'b00);
        apb_read(plic_addr(periph_irq_pkg::PLIC_CLAIM_OFS, 1), 32'h1, 1'b0);
        set_irq_check(1'b1, 2'b00);
        repeat (4) @(posedge clk);
        end_test("threshold and second target");

        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
source/periph_bus_pkg.sv
source/periph_irq_pkg.sv
source/apb_slot_demux.sv
source/timer_regs.sv
source/timer_core.sv
source/plic_regs.sv
source/plic_core.sv
source/periph_top.sv
sim/periph_tb.sv

// File: Bender.yml
package:
  name: periph_subsys

sources:
  # Packages first
  - source/periph_bus_pkg.sv
  - source/periph_irq_pkg.sv
  # RTL
  - source/apb_slot_demux.sv
  - source/timer_regs.sv
  - source/timer_core.sv
  - source/plic_regs.sv
  - source/plic_core.sv
  - source/periph_top.sv
  # Testbench
  - target: test
    files:
      - sim/periph_tb.sv
